/* source/pipeline_params.svh */
`ifndef PIPELINE_PARAMS_SVH
`define PIPELINE_PARAMS_SVH

// width of the top and bot vectors.
`define VEC_WIDTH 128

// bot sequence number, wraps around.
`define INDEX_WIDTH 8

// lane depths in cycles, the popcount lane is the longer one.
`define SUBSET_LATENCY 2
`define POPCOUNT_LATENCY 4

// result FIFO size.
`define FIFO_DEPTH 16

// free entries kept back for records still in the lanes.
`define FIFO_MARGIN (`POPCOUNT_LATENCY + 2)

`endif

/* source/pipelineTypesPkg.sv */
`include "pipeline_params.svh"

package pipelineTypesPkg;

    // one top or bot vector.
    typedef logic [`VEC_WIDTH-1:0] vecT;

    // sequence number of an accepted bot within one top.
    typedef logic [`INDEX_WIDTH-1:0] botIndexT;

endpackage

/* source/resultTypesPkg.sv */
`include "pipeline_params.svh"

package resultTypesPkg;

    // shared-bit count, needs to reach VEC_WIDTH itself.
    typedef logic [$clog2(`VEC_WIDTH + 1)-1:0] countT;

    // one record as it sits in the result FIFO.
    typedef struct packed {
        pipelineTypesPkg::botIndexT index;
        logic                       isSubset;
        countT                      overlap;
    } resultT;

endpackage

/* source/delayLine.sv */
`timescale 1ns/1ps

module delayLine #(
    parameter int  CYCLES   = 1,
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    advance,
    input  payloadT dataIn,
    output payloadT dataOut
);

    payloadT stages [CYCLES]; // stages[0] takes the input.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= '0;
            end
        end else if (advance) begin
            stages[0] <= dataIn;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i - 1]; // shift one step along.
            end
        end
    end

    assign dataOut = stages[CYCLES - 1];

endmodule

/* source/pipelineManager.sv */
`timescale 1ns/1ps
`include "pipeline_params.svh"

module pipelineManager (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       startNewTop,
    input  pipelineTypesPkg::vecT      topIn,
    input  logic                       isBotInValid,
    output logic                       readyForBotIn,
    input  logic                       fifoAlmostFull,
    output pipelineTypesPkg::vecT      top,
    output pipelineTypesPkg::botIndexT botIndex,
    output logic                       isBotValid,
    output logic                       resultValid
);

    import pipelineTypesPkg::*;

    localparam int DRAIN = `POPCOUNT_LATENCY;

    typedef logic [$clog2(DRAIN+1)-1:0] idleT;

    vecT  waitingTop;
    logic newTopWaiting;
    idleT idleCount;  // cycles since the last accepted bot.
    logic drainDone;

    // a pending top blocks new bots until it is loaded.
    assign readyForBotIn = !fifoAlmostFull && !newTopWaiting;
    assign isBotValid    = isBotInValid && readyForBotIn;

    // lanes still hold bots until DRAIN idle cycles have gone by.
    assign drainDone = newTopWaiting && (idleCount == idleT'(DRAIN));

    always_ff @(posedge clk) begin
        if (rst) begin
            newTopWaiting <= 1'b0;
            idleCount     <= idleT'(DRAIN); // pipeline starts empty.
            top           <= '0;
            botIndex      <= '0;
        end else begin
            if (drainDone) begin
                newTopWaiting <= 1'b0;
                top           <= waitingTop;
                botIndex      <= '0; // numbering restarts per top.
            end else if (startNewTop && !newTopWaiting) begin
                newTopWaiting <= 1'b1;
            end

            if (isBotValid) begin
                idleCount <= '0;
                botIndex  <= botIndex + 1'b1; // wraps.
            end else if (idleCount != idleT'(DRAIN)) begin
                idleCount <= idleCount + 1'b1;
            end
        end
    end

    // pending top captured with the pulse.
    always_ff @(posedge clk) begin
        if (startNewTop && !newTopWaiting) begin
            waitingTop <= topIn;
        end
    end

    // lanes never stall so validity simply follows the popcount depth.
    delayLine #(
        .CYCLES   (`POPCOUNT_LATENCY),
        .payloadT (logic)
    ) validDelay (
        .clk     (clk),
        .rst     (rst),
        .advance (1'b1),
        .dataIn  (isBotValid),
        .dataOut (resultValid)
    );

endmodule

/* source/subsetLane.sv */
`timescale 1ns/1ps
`include "pipeline_params.svh"

module subsetLane (
    input  logic                  clk,
    input  logic                  rst,
    input  pipelineTypesPkg::vecT top,
    input  pipelineTypesPkg::vecT bot,
    output logic                  subsetFlag
);

    localparam int GROUPS = `VEC_WIDTH / 4;

    logic [`VEC_WIDTH-1:0] missing;      // set in bot but absent in top.
    logic [GROUPS-1:0]     partialMiss;  // stage 1, one flag per nibble.

    assign missing = bot & ~top;

    always_ff @(posedge clk) begin
        if (rst) begin
            partialMiss <= '0;
        end else begin
            for (int i = 0; i < GROUPS; i++) begin
                partialMiss[i] <= |missing[4*i +: 4];
            end
        end
    end

    // stage 2, subset only if no nibble reported a miss.
    always_ff @(posedge clk) begin
        if (rst) begin
            subsetFlag <= 1'b0;
        end else begin
            subsetFlag <= ~|partialMiss;
        end
    end

endmodule

/* source/popcountLane.sv */
`timescale 1ns/1ps
`include "pipeline_params.svh"

module popcountLane (
    input  logic                  clk,
    input  logic                  rst,
    input  pipelineTypesPkg::vecT top,
    input  pipelineTypesPkg::vecT bot,
    output resultTypesPkg::countT overlap
);

    import pipelineTypesPkg::*;
    import resultTypesPkg::*;

    localparam int N4  = `VEC_WIDTH / 4;
    localparam int N16 = `VEC_WIDTH / 16;
    localparam int N64 = `VEC_WIDTH / 64;

    vecT        shared;
    logic [2:0] cnt4  [N4];  // ones per 4 bits.
    logic [4:0] cnt16 [N16]; // ones per 16 bits.
    logic [6:0] cnt64 [N64]; // ones per 64 bits.

    function automatic logic [2:0] ones4(input logic [3:0] bits);
        return 3'(bits[0]) + 3'(bits[1]) + 3'(bits[2]) + 3'(bits[3]);
    endfunction

    assign shared = bot & top;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N4; i++) begin
                cnt4[i] <= '0;
            end
            for (int i = 0; i < N16; i++) begin
                cnt16[i] <= '0;
            end
            for (int i = 0; i < N64; i++) begin
                cnt64[i] <= '0;
            end
            overlap <= '0;
        end else begin
            for (int i = 0; i < N4; i++) begin
                cnt4[i] <= ones4(shared[4*i +: 4]);
            end
            for (int i = 0; i < N16; i++) begin
                cnt16[i] <= 5'(cnt4[4*i]) + 5'(cnt4[4*i+1])
                          + 5'(cnt4[4*i+2]) + 5'(cnt4[4*i+3]);
            end
            for (int i = 0; i < N64; i++) begin
                cnt64[i] <= 7'(cnt16[4*i]) + 7'(cnt16[4*i+1])
                          + 7'(cnt16[4*i+2]) + 7'(cnt16[4*i+3]);
            end
            overlap <= countT'(cnt64[0]) + countT'(cnt64[1]); // whole vector.
        end
    end

endmodule

/* source/resultCombiner.sv */
`timescale 1ns/1ps
`include "pipeline_params.svh"

module resultCombiner (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       resultValid,
    input  pipelineTypesPkg::botIndexT botIndex,
    input  logic                       subsetFlag,
    input  resultTypesPkg::countT      overlap,
    input  logic                       resultRead,
    output resultTypesPkg::resultT     resultOut,
    output logic                       resultAvailable,
    output logic                       fifoAlmostFull
);

    import pipelineTypesPkg::*;
    import resultTypesPkg::*;

    localparam int DEPTH    = `FIFO_DEPTH;
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int FILL_MAX = DEPTH - `FIFO_MARGIN; // highest fill that still admits bots.

    logic                alignedFlag;
    botIndexT            alignedIndex;
    resultT              record;
    resultT              mem [DEPTH];
    logic [PTR_W-1:0]    wrPtr;
    logic [PTR_W-1:0]    rdPtr;
    logic [PTR_W:0]      fillCount;
    logic                doRead;

    // subset result is ready early, hold it back to meet the popcount.
    delayLine #(
        .CYCLES   (`POPCOUNT_LATENCY - `SUBSET_LATENCY),
        .payloadT (logic)
    ) flagDelay (
        .clk     (clk),
        .rst     (rst),
        .advance (1'b1),
        .dataIn  (subsetFlag),
        .dataOut (alignedFlag)
    );

    // index travels alongside the lanes.
    delayLine #(
        .CYCLES   (`POPCOUNT_LATENCY),
        .payloadT (botIndexT)
    ) indexDelay (
        .clk     (clk),
        .rst     (rst),
        .advance (1'b1),
        .dataIn  (botIndex),
        .dataOut (alignedIndex)
    );

    assign record = '{index: alignedIndex, isSubset: alignedFlag, overlap: overlap};

    assign resultAvailable = (fillCount != '0);
    assign doRead          = resultRead && resultAvailable; // empty reads are ignored.
    assign fifoAlmostFull  = (fillCount > FILL_MAX);
    assign resultOut       = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (resultValid) begin
            mem[wrPtr] <= record;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (resultValid) begin
                wrPtr <= wrPtr + 1'b1; // depth is a power of two.
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({resultValid, doRead})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

endmodule

/* source/botPipelineTop.sv */
`timescale 1ns/1ps

module botPipelineTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   startNewTop,
    input  pipelineTypesPkg::vecT  topIn,
    input  logic                   isBotInValid,
    input  pipelineTypesPkg::vecT  botIn,
    output logic                   readyForBotIn,
    input  logic                   resultRead,
    output resultTypesPkg::resultT resultOut,
    output logic                   resultAvailable
);

    import pipelineTypesPkg::*;
    import resultTypesPkg::*;

    vecT      top;          // current top, read by both lanes.
    botIndexT botIndex;
    logic     resultValid;
    logic     fifoAlmostFull;
    logic     subsetFlag;
    countT    overlap;

    pipelineManager manager (
        .clk            (clk),
        .rst            (rst),
        .startNewTop    (startNewTop),
        .topIn          (topIn),
        .isBotInValid   (isBotInValid),
        .readyForBotIn  (readyForBotIn),
        .fifoAlmostFull (fifoAlmostFull),
        .top            (top),
        .botIndex       (botIndex),
        .isBotValid     (),              // lanes run every cycle.
        .resultValid    (resultValid)
    );

    subsetLane subset (
        .clk        (clk),
        .rst        (rst),
        .top        (top),
        .bot        (botIn),
        .subsetFlag (subsetFlag)
    );

    popcountLane popcount (
        .clk     (clk),
        .rst     (rst),
        .top     (top),
        .bot     (botIn),
        .overlap (overlap)
    );

    resultCombiner combiner (
        .clk             (clk),
        .rst             (rst),
        .resultValid     (resultValid),
        .botIndex        (botIndex),
        .subsetFlag      (subsetFlag),
        .overlap         (overlap),
        .resultRead      (resultRead),
        .resultOut       (resultOut),
        .resultAvailable (resultAvailable),
        .fifoAlmostFull  (fifoAlmostFull)
    );

endmodule

/* dv/botPipelineTb.sv */
`timescale 1ns/1ps
`include "pipeline_params.svh"

module botPipelineTb;

    import pipelineTypesPkg::*;
    import resultTypesPkg::*;

    localparam int MAX_CYCLES = 3000; // roughly ten times the full test length.

    logic     clk;
    logic     rst;
    logic     startNewTop;
    vecT      topIn;
    logic     isBotInValid;
    vecT      botIn;
    logic     readyForBotIn;
    logic     resultRead;
    resultT   resultOut;
    logic     resultAvailable;

    integer   seed = 46909;
    int       cycleCount = 0;
    int       lastAcceptCycle = 0;
    int       mismatchCount = 0;
    int       failCount = 0;
    int       checkedCount = 0;
    int       readMode = 0;      // 0 off, 1 random, 2 every cycle.
    logic [31:0] readBits;
    vecT      refTop;            // top that newly accepted bots are tested against.
    botIndexT refIndex;
    resultT   expected [$];
    resultT   headExp;

    botPipelineTop UUT (
        .clk             (clk),
        .rst             (rst),
        .startNewTop     (startNewTop),
        .topIn           (topIn),
        .isBotInValid    (isBotInValid),
        .botIn           (botIn),
        .readyForBotIn   (readyForBotIn),
        .resultRead      (resultRead),
        .resultOut       (resultOut),
        .resultAvailable (resultAvailable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected record straight from the subset and overlap rules.
    function automatic resultT expectedRecord(input vecT topVec, input vecT botVec,
                                              input botIndexT idx);
        resultT rec;
        int     ones;
        logic   isSub;
        ones  = 0;
        isSub = 1'b1;
        for (int i = 0; i < `VEC_WIDTH; i++) begin
            if (topVec[i] && botVec[i]) begin
                ones++;
            end
            if (botVec[i] && !topVec[i]) begin
                isSub = 1'b0; // bot bit outside the top.
            end
        end
        rec.index    = idx;
        rec.isSubset = isSub;
        rec.overlap  = countT'(ones);
        return rec;
    endfunction

    function automatic vecT randomVec();
        vecT v;
        for (int i = 0; i < `VEC_WIDTH / 32; i++) begin
            v[32*i +: 32] = $random(seed);
        end
        return v;
    endfunction

    // a bot seen here with ready high is taken at the next edge.
    always @(negedge clk) begin
        if (!rst && isBotInValid && readyForBotIn) begin
            expected.push_back(expectedRecord(refTop, botIn, refIndex));
            refIndex        = refIndex + 1'b1;
            lastAcceptCycle = cycleCount;
        end
    end

    // compare the head record whenever a read really pops.
    always @(negedge clk) begin
        if (!rst && resultRead && resultAvailable) begin
            if (expected.size() == 0) begin
                failCount++;
                $display("ERROR at %0t: a record was read but none was expected", $time);
            end else begin
                headExp = expected.pop_front();
                checkedCount++;
                if (resultOut !== headExp) begin
                    mismatchCount++;
                    $display("MISMATCH at %0t: index %0d/%0d subset %0b/%0b overlap %0d/%0d",
                             $time, resultOut.index, headExp.index, resultOut.isSubset,
                             headExp.isSubset, resultOut.overlap, headExp.overlap);
                end
            end
        end
    end

    // new read pattern each cycle.
    always @(negedge clk) begin
        readBits = $random(seed);
    end

    // read strobe generator.
    always @(posedge clk) begin
        case (readMode)
            0:       resultRead <= 1'b0;
            1:       resultRead <= readBits[0] | readBits[1];
            default: resultRead <= 1'b1;
        endcase
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("TIMEOUT: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d mismatches, %0d other", mismatchCount, failCount);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic sendBots(input int count, input int subsetEvery);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            isBotInValid <= 1'b1;
            if (i % subsetEvery == 0) begin
                botIn <= randomVec() & refTop; // forced subset.
            end else begin
                botIn <= randomVec();
            end
        end
        @(posedge clk);
        isBotInValid <= 1'b0;
    endtask

    task automatic issueNewTop(input vecT newTop);
        @(posedge clk);
        isBotInValid <= 1'b0;
        startNewTop  <= 1'b1;
        topIn        <= newTop;
        refTop   = newTop;
        refIndex = '0;
        @(posedge clk);
        startNewTop <= 1'b0;
        @(negedge clk);
        if (readyForBotIn) begin
            failCount++;
            $display("ERROR at %0t: readyForBotIn stayed high after startNewTop", $time);
        end
        while (!readyForBotIn) begin
            @(negedge clk);
        end
        if (cycleCount - lastAcceptCycle <= `POPCOUNT_LATENCY) begin
            failCount++;
            $display("ERROR at %0t: readyForBotIn rose before the pipeline drained", $time);
        end
    endtask

    task automatic drainResults();
        readMode = 1;
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic checkBackPressure(input int cycles);
        bit sawStall;
        int sizeAtStall;
        sawStall    = 1'b0;
        sizeAtStall = 0;
        readMode    = 0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            isBotInValid <= 1'b1;
            botIn        <= randomVec();
            @(negedge clk);
            if (!readyForBotIn && !sawStall) begin
                sawStall    = 1'b1;
                sizeAtStall = expected.size();
            end
            if (expected.size() > `FIFO_DEPTH) begin
                failCount++;
                $display("ERROR at %0t: more bots accepted than the FIFO can hold", $time);
            end
        end
        @(posedge clk);
        isBotInValid <= 1'b0;
        if (!sawStall || sizeAtStall >= `FIFO_DEPTH) begin
            failCount++;
            $display("ERROR at %0t: readyForBotIn did not fall before the FIFO filled", $time);
        end
    endtask

    initial begin
        rst          = 1'b1;
        startNewTop  = 1'b0;
        topIn        = '0;
        isBotInValid = 1'b0;
        botIn        = '0;
        resultRead   = 1'b0;
        refTop       = '0;
        refIndex     = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!readyForBotIn || resultAvailable) begin
            failCount++;
            $display("ERROR at %0t: wrong readyForBotIn or resultAvailable after reset", $time);
        end

        // reads on an empty FIFO must not pop anything.
        readMode = 2;
        repeat (4) @(negedge clk);
        if (resultAvailable) begin
            failCount++;
            $display("ERROR at %0t: resultAvailable rose after reads on an empty FIFO", $time);
        end

        readMode = 1;
        sendBots(8, 3);             // against the all-zero top.
        issueNewTop(randomVec());
        sendBots(60, 4);
        issueNewTop(randomVec());   // earlier records still in flight.
        sendBots(60, 5);
        drainResults();

        checkBackPressure(40);
        drainResults();

        issueNewTop(randomVec());
        sendBots(20, 2);
        drainResults();

        if (resultAvailable || expected.size() != 0) begin
            failCount++;
            $display("ERROR at %0t: records left over after reading everything", $time);
        end
        if (checkedCount == 0) begin
            failCount++;
            $display("ERROR: no result record was ever checked");
        end
        $display("errors: %0d mismatches, %0d other, %0d records checked",
                 mismatchCount, failCount, checkedCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/pipelineTypesPkg.sv
source/resultTypesPkg.sv
source/delayLine.sv
source/pipelineManager.sv
source/subsetLane.sv
source/popcountLane.sv
source/resultCombiner.sv
source/botPipelineTop.sv
dv/botPipelineTb.sv
